//--- reg_main_top.f
reg_main_pkg.sv
capture_ctrl_regs.sv
phase_shift_ctrl.sv
fifo_reg_reader.sv
read_data_mux.sv
reg_main_top.sv
tb_reg_main.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := tb_reg_main
FILELIST  := reg_main_top.f

SRCS := $(shell cat $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir

//--- tb_reg_main.sv
// main register block testbench: table-driven register accesses, strobes and a FIFO model
module tb_reg_main
   import reg_main_pkg::*;
;
   timeunit 1ns;
   timeprecision 100ps;

   typedef struct {
      logic [5:0] addr;
      logic [6:0] cnt;
      bit         wr;
      logic [7:0] data;
      logic [7:0] exp;
   } entry_t;

   logic cwusb_clk = 1'b0, fpga_reset;
   logic [7:0] reg_address, write_data, read_data;
   logic [bytecnt_w-1:0] reg_bytecnt;
   logic reg_read, reg_write, reg_addrvalid, sys_reset, fifo_read, fifo_empty;
   logic [17:0] fifo_data;
   logic [5:0] fifo_status;
   logic flushing, capture_enable_pulse, arm, reg_arm_out, arm_pulse, capture_off;
   logic capture_now, clear_errors, trigger_enable, psen, psincdec, psdone, locked1, locked2;
   logic [capture_len_w-1:0] capture_len;
   logic [trig_all_w-1:0] trigger_delay, trigger_width;
   logic [num_trig_w-1:0] num_triggers, triggers_generated;
   logic [15:0] max_timestamp;
   logic [31:0] buildtime;

   entry_t      table_q[$];
   logic [17:0] fifo_q[$];
   int          errors = 0;
   int          pops = 0;
   logic [31:0] rng = 32'hcf0c1200;

   reg_main_top DUT (.*);

   always #20 cwusb_clk = ~cwusb_clk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   task automatic check(input string msg, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
      end
   endtask

   // head of the model queue drives the FIFO inputs
   task automatic refresh_fifo();
      fifo_empty = (fifo_q.size() == 0);
      fifo_data  = fifo_empty ? 18'd0 : fifo_q[0];
   endtask

   always @(posedge cwusb_clk) begin
      if (fifo_read === 1'b1) begin
         pops++;
         #1;
         if (fifo_q.size() > 0)
            void'(fifo_q.pop_front());
         refresh_fifo();
      end
   end

   // one access, starting 2 ns after an edge; read data is sampled one clock later
   task automatic reg_access(input logic [5:0] addr, input logic [6:0] cnt, input bit wr,
                             input logic [7:0] data, output logic [7:0] rd);
      reg_address   = {main_reg_select, addr};
      reg_bytecnt   = cnt;
      write_data    = data;
      reg_addrvalid = 1'b1;
      reg_write     = wr;
      reg_read      = !wr;
      @(posedge cwusb_clk);
      #2;
      reg_write     = 1'b0;
      reg_read      = 1'b0;
      reg_addrvalid = 1'b0;
      rd            = read_data;
   endtask

   task automatic idle(input int n);
      repeat (n) @(posedge cwusb_clk);
      #2;
   endtask

   task automatic wait_reset_release();
      int n;
      n = 0;
      while (sys_reset && n < 10) begin
         idle(1);
         n++;
      end
      if (sys_reset) begin
         errors++;
         $display("timeout: sys_reset stayed high after the soft reset was cleared");
      end
   endtask

   task automatic add(input logic [5:0] a, input int c, input bit w, input logic [7:0] d,
                      input logic [7:0] e);
      entry_t t;
      t.addr = a;
      t.cnt  = 7'(c);
      t.wr   = w;
      t.data = d;
      t.exp  = e;
      table_q.push_back(t);
   endtask

   // four-byte FIFO register read, checked against the expected word
   task automatic fifo_word_read(input logic [17:0] word, input int exp_pops);
      logic [7:0] rd;
      int p0;
      p0 = pops;
      idle(1);  // reg_read low for a cycle so byte 0 opens a new read
      for (int b = 0; b < 4; b++) begin
         reg_access(reg_fifo_rd, 7'(b), 1'b0, 8'd0, rd);
         case (b)
            1: check("fifo byte 1", rd, word[7:0]);
            2: check("fifo byte 2", rd, word[15:8]);
            3: check("fifo byte 3", rd, {fifo_status, word[17:16]});
            default: check("fifo byte 0", rd, 8'd0);
         endcase
      end
      check("fifo pops per word", pops - p0, exp_pops);
   endtask

   initial begin
      logic [7:0] rd;
      logic [47:0] exp_delay, exp_width;
      logic [23:0] exp_len;
      logic [15:0] exp_ts;
      logic [17:0] w0, w1;
      int p0;

      fpga_reset = 1'b1;
      reg_address = 8'd0;
      reg_bytecnt = '0;
      write_data = 8'd0;
      {reg_read, reg_write, reg_addrvalid} = 3'b000;
      {flushing, capture_enable_pulse, psdone} = 3'b000;
      {locked1, locked2} = 2'b11;
      fifo_status = 6'h2b;
      triggers_generated = 4'd3;
      buildtime = 32'h5a3c_1e07;
      refresh_fifo();
      repeat (3) @(posedge cwusb_clk);
      #2;
      fpga_reset = 1'b0;

      ////////////////////////////////////////////////////////////
      // reset values and random configuration, from the table
      ////////////////////////////////////////////////////////////
      check("strobes after reset", {arm, arm_pulse, capture_now, psen, clear_errors, fifo_read},
            6'd0);
      add(reg_num_triggers, 0, 0, 0, 8'd1);
      add(reg_max_timestamp, 0, 0, 0, 8'hff);
      add(reg_max_timestamp, 1, 0, 0, 8'hff);
      add(reg_board_rev, 0, 0, 0, 8'd4);
      add(reg_buffer_size, 0, 0, 0, 8'd8);
      add(reg_fifo_stat, 0, 0, 0, 8'h2b);
      add(reg_triggers_generated, 0, 0, 0, 8'h03);
      add(reg_mmcm_locked, 0, 0, 0, 8'h03);
      for (int i = 0; i < 4; i++)
         add(reg_buildtime, i, 0, 0, buildtime[8*i +: 8]);
      for (int i = 0; i < 17; i++) begin
         rng = xorshift(rng);
         if (i < 6) begin
            add(reg_trigger_delay, i, 1, rng[7:0], 0);
            exp_delay[8*i +: 8] = rng[7:0];
         end else if (i < 12) begin
            add(reg_trigger_width, i - 6, 1, rng[7:0], 0);
            exp_width[8*(i-6) +: 8] = rng[7:0];
         end else if (i < 15) begin
            add(reg_capture_len, i - 12, 1, rng[7:0], 0);
            exp_len[8*(i-12) +: 8] = rng[7:0];
         end else begin
            add(reg_max_timestamp, i - 15, 1, rng[7:0], 0);
            exp_ts[8*(i-15) +: 8] = rng[7:0];
         end
      end
      add(reg_capture_off, 0, 1, 8'h01, 0);
      add(reg_trigger_enable, 0, 1, 8'h01, 0);
      add(reg_num_triggers, 0, 1, 8'h02, 0);
      for (int i = 0; i < 6; i++) begin
         add(reg_trigger_delay, i, 0, 0, exp_delay[8*i +: 8]);
         add(reg_trigger_width, i, 0, 0, exp_width[8*i +: 8]);
      end
      for (int i = 0; i < 3; i++)
         add(reg_capture_len, i, 0, 0, exp_len[8*i +: 8]);
      for (int i = 0; i < 2; i++)
         add(reg_max_timestamp, i, 0, 0, exp_ts[8*i +: 8]);
      add(reg_capture_off, 0, 0, 0, 8'h01);
      add(reg_trigger_enable, 0, 0, 0, 8'h01);
      add(reg_num_triggers, 0, 0, 0, 8'h02);

      foreach (table_q[i]) begin
         reg_access(table_q[i].addr, table_q[i].cnt, table_q[i].wr, table_q[i].data, rd);
         if (!table_q[i].wr)
            check($sformatf("table row %0d", i), rd, table_q[i].exp);
      end
      check("trigger_delay out", trigger_delay, exp_delay);
      check("trigger_width out", trigger_width, exp_width);
      check("capture_len out", capture_len, exp_len);
      check("max_timestamp out", max_timestamp, exp_ts);
      check("capture_off out", capture_off, 1'b1);
      check("trigger_enable out", trigger_enable, 1'b1);
      check("num_triggers out", num_triggers, 4'd2);

      ////////////////////////////////////////////////////////////
      // arm and capture strobes
      ////////////////////////////////////////////////////////////
      reg_access(reg_arm, 0, 1'b1, 8'h01, rd);
      check("arm_pulse first cycle", arm_pulse, 1'b1);
      idle(1);
      check("arm_pulse second cycle", arm_pulse, 1'b0);
      check("arm", arm, 1'b1);
      flushing = 1'b1;
      #1;
      check("arm while flushing", arm, 1'b0);
      flushing = 1'b0;
      #1;
      reg_access(reg_arm, 0, 1'b1, 8'h02, rd);
      check("capture_now", capture_now, 1'b1);
      idle(1);
      check("capture_now end", capture_now, 1'b0);
      check("reg_arm_out set", reg_arm_out, 1'b1);
      capture_enable_pulse = 1'b1;
      idle(1);
      capture_enable_pulse = 1'b0;
      check("reg_arm_out cleared", reg_arm_out, 1'b0);

      ////////////////////////////////////////////////////////////
      // phase shift
      ////////////////////////////////////////////////////////////
      reg_access(reg_trig_clk_phase_shift, 0, 1'b1, 8'h01, rd);
      check("psen", psen, 1'b1);
      check("psincdec", psincdec, 1'b1);
      reg_access(reg_trig_clk_phase_shift, 0, 1'b1, 8'h00, rd);
      check("psen after one cycle", psen, 1'b0);
      check("psincdec kept on busy write", psincdec, 1'b1);
      reg_access(reg_trig_clk_phase_shift, 0, 1'b0, 8'h00, rd);
      check("phase shift busy", rd, 8'd1);
      psdone = 1'b1;
      idle(1);
      psdone = 1'b0;
      reg_access(reg_trig_clk_phase_shift, 0, 1'b0, 8'h00, rd);
      check("phase shift idle", rd, 8'd0);

      ////////////////////////////////////////////////////////////
      // FIFO reads, then the empty marker
      ////////////////////////////////////////////////////////////
      rng = xorshift(rng);
      w0 = rng[17:0];
      rng = xorshift(rng);
      w1 = rng[17:0];
      fifo_q.push_back(w0);
      fifo_q.push_back(w1);
      refresh_fifo();
      idle(2);
      fifo_word_read(w0, 1);
      fifo_word_read(w1, 1);
      idle(2);
      fifo_word_read({fifo_cmd_strm, fifo_strm_empty}, 0);
      fifo_q.push_back(w0);
      refresh_fifo();
      idle(2);
      p0 = pops;
      reg_access(reg_fifo_rd, 0, 1'b0, 8'd0, rd);
      check("no pop while marker clears", pops - p0, 0);
      fifo_word_read(w0, 1);

      ////////////////////////////////////////////////////////////
      // clear errors and soft reset
      ////////////////////////////////////////////////////////////
      reg_access(reg_clear_errors, 0, 1'b1, 8'h01, rd);
      check("clear_errors", clear_errors, 1'b1);
      idle(1);
      check("clear_errors end", clear_errors, 1'b0);
      reg_access(reg_reset_reg, 0, 1'b1, 8'h01, rd);
      check("sys_reset held", sys_reset, 1'b1);
      idle(2);
      check("sys_reset still held", sys_reset, 1'b1);
      check("num_triggers reset", num_triggers, 4'd1);
      check("max_timestamp reset", max_timestamp, 16'hffff);
      check("trigger_delay reset", trigger_delay, 48'd0);
      check("trigger_width reset", trigger_width, 48'd0);
      check("capture_len reset", capture_len, 24'd0);
      check("capture_off reset", capture_off, 1'b0);
      check("trigger_enable reset", trigger_enable, 1'b0);
      reg_access(reg_reset_reg, 0, 1'b1, 8'h00, rd);
      wait_reset_release();

      $display("errors: %0d, table rows: %0d", errors, table_q.size());
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

//--- reg_main_top.sv
// main register block top: address decode and wiring of the register submodules
module reg_main_top
   import reg_main_pkg::*;
(
   input  logic                     cwusb_clk,
   input  logic                     fpga_reset,

   // register port
   input  logic [7:0]               reg_address,
   input  logic [bytecnt_w-1:0]     reg_bytecnt,
   input  logic [7:0]               write_data,
   input  logic                     reg_read,
   input  logic                     reg_write,
   input  logic                     reg_addrvalid,
   output logic [7:0]               read_data,
   output logic                     sys_reset,

   // capture FIFO
   input  logic [17:0]              fifo_data,
   input  logic [5:0]               fifo_status,
   input  logic                     fifo_empty,
   output logic                     fifo_read,

   // capture control
   input  logic                     flushing,
   input  logic                     capture_enable_pulse,
   output logic                     arm,
   output logic                     reg_arm_out,
   output logic                     arm_pulse,
   output logic                     capture_off,
   output logic                     capture_now,
   output logic                     clear_errors,
   output logic [capture_len_w-1:0] capture_len,
   output logic [15:0]              max_timestamp,

   // trigger generator
   input  logic [num_trig_w-1:0]    triggers_generated,
   output logic                     trigger_enable,
   output logic [trig_all_w-1:0]    trigger_delay,
   output logic [trig_all_w-1:0]    trigger_width,
   output logic [num_trig_w-1:0]    num_triggers,

   // trigger clock phase shift and MMCM status
   input  logic                     psdone,
   input  logic                     locked1,
   input  logic                     locked2,
   output logic                     psen,
   output logic                     psincdec,

   input  logic [31:0]              buildtime
);

   logic       selected;
   logic [5:0] address;
   logic       phaseshift_active;
   fifo_word_t fifo_word;

   assign selected = reg_addrvalid && (reg_address[7:6] == main_reg_select);
   assign address  = reg_address[5:0];

   capture_ctrl_regs u_capture_ctrl_regs (
      .cwusb_clk            (cwusb_clk),
      .fpga_reset           (fpga_reset),
      .selected             (selected),
      .address              (address),
      .reg_bytecnt          (reg_bytecnt),
      .write_data           (write_data),
      .reg_write            (reg_write),
      .flushing             (flushing),
      .capture_enable_pulse (capture_enable_pulse),
      .sys_reset            (sys_reset),
      .arm                  (arm),
      .reg_arm_out          (reg_arm_out),
      .arm_pulse            (arm_pulse),
      .capture_now          (capture_now),
      .capture_off          (capture_off),
      .clear_errors         (clear_errors),
      .trigger_enable       (trigger_enable),
      .trigger_delay        (trigger_delay),
      .trigger_width        (trigger_width),
      .num_triggers         (num_triggers),
      .capture_len          (capture_len),
      .max_timestamp        (max_timestamp)
   );

   phase_shift_ctrl u_phase_shift_ctrl (
      .cwusb_clk         (cwusb_clk),
      .sys_reset         (sys_reset),
      .selected          (selected),
      .address           (address),
      .write_data        (write_data),
      .reg_write         (reg_write),
      .psdone            (psdone),
      .psen              (psen),
      .psincdec          (psincdec),
      .phaseshift_active (phaseshift_active)
   );

   fifo_reg_reader u_fifo_reg_reader (
      .cwusb_clk   (cwusb_clk),
      .sys_reset   (sys_reset),
      .selected    (selected),
      .address     (address),
      .reg_bytecnt (reg_bytecnt),
      .reg_read    (reg_read),
      .fifo_data   (fifo_data),
      .fifo_empty  (fifo_empty),
      .fifo_read   (fifo_read),
      .fifo_word   (fifo_word)
   );

   read_data_mux u_read_data_mux (
      .cwusb_clk          (cwusb_clk),
      .selected           (selected),
      .address            (address),
      .reg_bytecnt        (reg_bytecnt),
      .reg_read           (reg_read),
      .buildtime          (buildtime),
      .fifo_status        (fifo_status),
      .fifo_word          (fifo_word),
      .reg_arm_out        (reg_arm_out),
      .capture_off        (capture_off),
      .trigger_enable     (trigger_enable),
      .trigger_delay      (trigger_delay),
      .trigger_width      (trigger_width),
      .num_triggers       (num_triggers),
      .capture_len        (capture_len),
      .max_timestamp      (max_timestamp),
      .phaseshift_active  (phaseshift_active),
      .triggers_generated (triggers_generated),
      .locked1            (locked1),
      .locked2            (locked2),
      .read_data          (read_data)
   );

endmodule

//--- read_data_mux.sv
// register readback multiplexer with registered byte output
module read_data_mux
   import reg_main_pkg::*;
(
   input  logic                     cwusb_clk,
   input  logic                     selected,
   input  logic [5:0]               address,
   input  logic [bytecnt_w-1:0]     reg_bytecnt,
   input  logic                     reg_read,
   input  logic [31:0]              buildtime,
   input  logic [5:0]               fifo_status,
   input  fifo_word_t               fifo_word,
   input  logic                     reg_arm_out,
   input  logic                     capture_off,
   input  logic                     trigger_enable,
   input  logic [trig_all_w-1:0]    trigger_delay,
   input  logic [trig_all_w-1:0]    trigger_width,
   input  logic [num_trig_w-1:0]    num_triggers,
   input  logic [capture_len_w-1:0] capture_len,
   input  logic [15:0]              max_timestamp,
   input  logic                     phaseshift_active,
   input  logic [num_trig_w-1:0]    triggers_generated,
   input  logic                     locked1,
   input  logic                     locked2,
   output logic [7:0]               read_data
);

   logic [7:0] read_data_pre;

   // byte idx of a zero-extended word, 0 past its end
   function automatic logic [7:0] byte_of(input logic [63:0] word,
                                          input logic [bytecnt_w-1:0] idx);
      logic [7:0] b;
      b = 8'd0;
      if (idx < bytecnt_w'(8))
         b = word[8*idx[2:0] +: 8];
      return b;
   endfunction

   ////////////////////////////////////////////////////////////
   // readback select
   ////////////////////////////////////////////////////////////

   always_comb begin
      read_data_pre = 8'd0;
      if (selected && reg_read) begin
         case (address)
            reg_buildtime:            read_data_pre = buildtime[8*reg_bytecnt[1:0] +: 8];
            reg_fifo_stat:            read_data_pre = {2'b00, fifo_status};
            reg_arm:                  read_data_pre = {7'd0, reg_arm_out};
            reg_capture_off:          read_data_pre = {7'd0, capture_off};
            reg_trigger_enable:       read_data_pre = {7'd0, trigger_enable};
            reg_trigger_delay:
               read_data_pre = byte_of(64'(trigger_delay), reg_bytecnt);
            reg_trigger_width:
               read_data_pre = byte_of(64'(trigger_width), reg_bytecnt);
            reg_num_triggers:         read_data_pre = 8'(num_triggers);
            reg_triggers_generated:   read_data_pre = 8'(triggers_generated);
            reg_trig_clk_phase_shift: read_data_pre = {7'd0, phaseshift_active};
            reg_capture_len:
               read_data_pre = byte_of(64'(capture_len), reg_bytecnt);
            reg_board_rev:            read_data_pre = board_rev_value;
            reg_mmcm_locked:          read_data_pre = {6'd0, locked2, locked1};
            reg_max_timestamp:        read_data_pre = max_timestamp[8*reg_bytecnt[0] +: 8];
            reg_buffer_size:          read_data_pre = 8'(buffer_size_bits / 8);
            reg_fifo_rd: begin
               case (reg_bytecnt[1:0])
                  2'd1:    read_data_pre = fifo_word.raw[7:0];
                  2'd2:    read_data_pre = fifo_word.raw[15:8];
                  2'd3:    read_data_pre = {fifo_status, fifo_word.raw[17:16]};
                  default: read_data_pre = 8'd0;  // byte 0 is the pop cycle
               endcase
            end
            default:                  read_data_pre = 8'd0;
         endcase
      end
   end

   // one clock of read latency
   always_ff @(posedge cwusb_clk) begin
      read_data <= read_data_pre;
   end

endmodule

//--- fifo_reg_reader.sv
// capture FIFO access through the FIFO read register, with streaming empty marker
module fifo_reg_reader
   import reg_main_pkg::*;
(
   input  logic                 cwusb_clk,
   input  logic                 sys_reset,
   input  logic                 selected,
   input  logic [5:0]           address,
   input  logic [bytecnt_w-1:0] reg_bytecnt,
   input  logic                 reg_read,
   input  logic [17:0]          fifo_data,
   input  logic                 fifo_empty,
   output logic                 fifo_read,
   output fifo_word_t           fifo_word
);

   logic        reg_read_r;
   logic        fifo_empty_r;
   logic [1:0]  last_bytecnt;   // byte count of the previous read cycle
   logic        empty_marker;
   logic [17:0] fifo_data_r;
   logic        fifo_sel;
   logic        read_start;

   assign fifo_sel   = selected && (address == reg_fifo_rd) && (reg_bytecnt[1:0] == 2'd0);
   assign read_start = fifo_sel && reg_read && !reg_read_r;

   // pop on the first cycle of byte 0
   assign fifo_read = read_start && !fifo_empty_r && !empty_marker;

   always_ff @(posedge cwusb_clk) begin
      if (sys_reset) begin
         reg_read_r   <= 1'b0;
         fifo_empty_r <= 1'b0;
         last_bytecnt <= 2'd0;
         empty_marker <= 1'b0;
      end else begin
         reg_read_r   <= reg_read;
         fifo_empty_r <= fifo_empty;
         if (reg_read)
            last_bytecnt <= reg_bytecnt[1:0];

         // word started on an empty FIFO reads back as a stream-empty command
         if (read_start && fifo_empty_r)
            empty_marker <= 1'b1;
         else if (fifo_sel && reg_read && (last_bytecnt == 2'd3) && !fifo_empty_r)
            empty_marker <= 1'b0;
      end
   end

   always_ff @(posedge cwusb_clk) begin
      if (fifo_read)
         fifo_data_r <= fifo_data;
   end

   always_comb begin
      fifo_word.raw = fifo_data_r;
      if (empty_marker) begin
         fifo_word.cmd.cmd     = fifo_cmd_strm;
         fifo_word.cmd.payload = fifo_strm_empty;
      end
   end

endmodule

//--- phase_shift_ctrl.sv
// trigger clock phase shift: one MMCM step per register write, busy until psdone
module phase_shift_ctrl
   import reg_main_pkg::*;
(
   input  logic       cwusb_clk,
   input  logic       sys_reset,
   input  logic       selected,
   input  logic [5:0] address,
   input  logic [7:0] write_data,
   input  logic       reg_write,
   input  logic       psdone,
   output logic       psen,
   output logic       psincdec,
   output logic       phaseshift_active
);

   logic ps_req;

   // writes while a step is in flight are dropped
   assign ps_req = selected && reg_write && (address == reg_trig_clk_phase_shift)
                   && !phaseshift_active;

   always_ff @(posedge cwusb_clk) begin
      if (sys_reset) begin
         psen              <= 1'b0;
         psincdec          <= 1'b0;
         phaseshift_active <= 1'b0;
      end else if (ps_req) begin
         psen              <= 1'b1;
         psincdec          <= write_data[0];  // 1 = increment
         phaseshift_active <= 1'b1;
      end else begin
         psen <= 1'b0;
         if (psdone)
            phaseshift_active <= 1'b0;
      end
   end

endmodule

//--- capture_ctrl_regs.sv
// capture and trigger configuration registers, arm/capture/clear strobes and soft reset
module capture_ctrl_regs
   import reg_main_pkg::*;
(
   input  logic                     cwusb_clk,
   input  logic                     fpga_reset,
   input  logic                     selected,
   input  logic [5:0]               address,
   input  logic [bytecnt_w-1:0]     reg_bytecnt,
   input  logic [7:0]               write_data,
   input  logic                     reg_write,
   input  logic                     flushing,
   input  logic                     capture_enable_pulse,
   output logic                     sys_reset,
   output logic                     arm,
   output logic                     reg_arm_out,
   output logic                     arm_pulse,
   output logic                     capture_now,
   output logic                     capture_off,
   output logic                     clear_errors,
   output logic                     trigger_enable,
   output logic [trig_all_w-1:0]    trigger_delay,
   output logic [trig_all_w-1:0]    trigger_width,
   output logic [num_trig_w-1:0]    num_triggers,
   output logic [capture_len_w-1:0] capture_len,
   output logic [15:0]              max_timestamp
);

   logic wr_hit;
   logic arm_q;
   logic arm_r;
   logic soft_reset = 1'b0;  // survives its own reset, only a write changes it

   assign wr_hit = selected && reg_write;

   assign sys_reset   = fpga_reset || soft_reset;
   assign reg_arm_out = arm_q;
   assign arm_pulse   = arm_q && !arm_r;   // first cycle of arm_q
   assign arm         = arm_r && !flushing;

   ////////////////////////////////////////////////////////////
   // configuration registers, byte-wide writes
   ////////////////////////////////////////////////////////////

   always_ff @(posedge cwusb_clk) begin
      if (sys_reset) begin
         capture_off    <= 1'b0;
         trigger_enable <= 1'b0;
         trigger_delay  <= '0;
         trigger_width  <= '0;
         num_triggers   <= num_trig_w'(1);
         capture_len    <= '0;
         max_timestamp  <= 16'hFFFF;
      end else if (wr_hit) begin
         case (address)
            reg_capture_off:    capture_off    <= write_data[0];
            reg_trigger_enable: trigger_enable <= write_data[0];
            reg_trigger_delay:  trigger_delay[8*reg_bytecnt +: 8] <= write_data;
            reg_trigger_width:  trigger_width[8*reg_bytecnt +: 8] <= write_data;
            reg_num_triggers:   num_triggers   <= write_data[num_trig_w-1:0];
            reg_capture_len:    capture_len[8*reg_bytecnt +: 8]   <= write_data;
            reg_max_timestamp:  max_timestamp[8*reg_bytecnt[0] +: 8] <= write_data;
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // strobes
   ////////////////////////////////////////////////////////////

   always_ff @(posedge cwusb_clk) begin
      if (sys_reset) begin
         arm_q        <= 1'b0;
         arm_r        <= 1'b0;
         capture_now  <= 1'b0;
         clear_errors <= 1'b0;
      end else begin
         arm_r <= arm_q;

         // a new arm wins over a capture start in the same cycle
         if (wr_hit && (address == reg_arm) && write_data[0])
            arm_q <= 1'b1;
         else if (capture_enable_pulse)
            arm_q <= 1'b0;

         capture_now  <= wr_hit && (address == reg_arm) && write_data[1];
         clear_errors <= wr_hit && (address == reg_clear_errors) && !clear_errors;
      end
   end

   // register-triggered reset, held until bit 0 is written back to 0
   always_ff @(posedge cwusb_clk) begin
      if (wr_hit && (address == reg_reset_reg))
         soft_reset <= write_data[0];
   end

endmodule

//--- reg_main_pkg.sv
// main register block constants: block select, register map, widths and FIFO word layout
package reg_main_pkg;

   ////////////////////////////////////////////////////////////
   // block select and field widths
   ////////////////////////////////////////////////////////////

   localparam logic [1:0] main_reg_select = 2'd0;  // reg_address[7:6] must match

   localparam int bytecnt_w       = 7;
   localparam int capture_len_w   = 24;
   localparam int num_trig_pulses = 2;
   localparam int trig_field_w    = 24;  // one delay or one width
   localparam int trig_all_w      = num_trig_pulses * trig_field_w;
   localparam int num_trig_w      = 4;

   localparam int buffer_size_bits = 64;           // read back in bytes
   localparam logic [7:0] board_rev_value = 8'd4;  // production boards

   ////////////////////////////////////////////////////////////
   // register addresses (reg_address[5:0])
   ////////////////////////////////////////////////////////////

   localparam logic [5:0] reg_buildtime            = 6'd0;
   localparam logic [5:0] reg_fifo_stat            = 6'd1;
   localparam logic [5:0] reg_arm                  = 6'd2;
   localparam logic [5:0] reg_capture_off          = 6'd3;
   localparam logic [5:0] reg_trigger_enable       = 6'd4;
   localparam logic [5:0] reg_trigger_delay        = 6'd5;
   localparam logic [5:0] reg_trigger_width        = 6'd6;
   localparam logic [5:0] reg_num_triggers         = 6'd7;
   localparam logic [5:0] reg_triggers_generated   = 6'd8;
   localparam logic [5:0] reg_trig_clk_phase_shift = 6'd9;
   localparam logic [5:0] reg_capture_len          = 6'd10;
   localparam logic [5:0] reg_board_rev            = 6'd11;
   localparam logic [5:0] reg_mmcm_locked          = 6'd12;
   localparam logic [5:0] reg_max_timestamp        = 6'd13;
   localparam logic [5:0] reg_buffer_size          = 6'd14;
   localparam logic [5:0] reg_fifo_rd              = 6'd15;
   localparam logic [5:0] reg_clear_errors         = 6'd16;
   localparam logic [5:0] reg_reset_reg            = 6'd17;

   ////////////////////////////////////////////////////////////
   // capture FIFO word
   ////////////////////////////////////////////////////////////

   localparam logic [1:0]  fifo_cmd_strm   = 2'b10;     // stream command
   localparam logic [15:0] fifo_strm_empty = 16'h0001;  // stream ran dry

   // one 18-bit FIFO entry, seen as stored data or as a stream command
   typedef union packed {
      logic [17:0] raw;
      struct packed {
         logic [1:0]  cmd;      // bits 17:16
         logic [15:0] payload;
      } cmd;
   } fifo_word_t;

endpackage
